//--- Bender.yml
package:
  name: qspi_loader

sources:
  - logic/loader_pkg.sv
  - logic/qspi_byte_rx.sv
  - logic/host_cmd_decoder.sv
  - logic/word_ram.sv
  - logic/map_ctrl_receiver.sv
  - logic/qspi_loader.sv
  - target: test
    files:
      - testbench/tb_clock.sv
      - testbench/tb_qspi_loader.sv

//--- compile.f
logic/loader_pkg.sv
logic/qspi_byte_rx.sv
logic/host_cmd_decoder.sv
logic/word_ram.sv
logic/map_ctrl_receiver.sv
logic/qspi_loader.sv
testbench/tb_clock.sv
testbench/tb_qspi_loader.sv

//--- logic/host_cmd_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module host_cmd_decoder (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic [7:0]                            rx_data,
    input  logic                                  rx_valid,
    input  logic                                  rx_closed,
    output logic                                  rx_ready,
    output logic [loader_pkg::ram_addr_width-1:0] ram_address,
    output logic [loader_pkg::ram_data_width-1:0] ram_data,
    output logic                                  ram_req,
    input  logic                                  ram_busy,
    output logic [loader_pkg::map_ctrl_width-1:0] map_ctrl,
    output logic                                  map_ctrl_req,
    input  logic                                  map_ctrl_ack
);

    import loader_pkg::*;

    decode_state_t state;
    logic [7:0]    cmd;
    logic [1:0]    byte_cnt;
    logic          low_first;
    logic          second_byte;
    logic          first_write;
    logic [1:0]    ack_sync;
    logic          write_blocked;
    logic          take_byte;

    // data bytes of a write wait while the memory is busy.
    assign write_blocked = (state == st_data) && (cmd == cmd_write) && ram_busy;
    assign take_byte     = rx_valid && !rx_ready && !write_blocked;

    always_ff @(posedge clk) begin
        if (reset) begin
            state        <= st_cmd;
            rx_ready     <= 1'b0;
            ram_req      <= 1'b0;
            map_ctrl_req <= 1'b0;
            ack_sync     <= 2'b00;
            byte_cnt     <= 2'd0;
            low_first    <= 1'b0;
            second_byte  <= 1'b0;
            first_write  <= 1'b0;
        end else begin
            rx_ready <= 1'b0;
            ram_req  <= 1'b0;
            ack_sync <= {ack_sync[0], map_ctrl_ack};

            if (rx_closed && !rx_valid) begin
                state <= st_cmd;
            end

            if (take_byte) begin
                rx_ready <= 1'b1;
                case (state)
                    st_cmd: begin
                        cmd      <= rx_data;
                        byte_cnt <= 2'd0;
                        state    <= st_addr;
                    end
                    st_addr: begin
                        byte_cnt <= byte_cnt + 2'd1;
                        if (byte_cnt == 2'd2) begin
                            state <= st_data;
                        end
                        if (cmd == cmd_write) begin
                            case (byte_cnt)
                                2'd0: ram_address[21:15] <= rx_data[6:0];
                                2'd1: ram_address[14:7] <= rx_data;
                                2'd2: begin
                                    // lsb picks the byte order within each word.
                                    ram_address[6:0] <= rx_data[7:1];
                                    low_first        <= rx_data[0];
                                    second_byte      <= 1'b0;
                                    first_write      <= 1'b1;
                                end
                                default: ;
                            endcase
                        end else if (cmd == cmd_launch) begin
                            case (byte_cnt)
                                2'd0: map_ctrl[23:16] <= rx_data;
                                2'd1: map_ctrl[15:8] <= rx_data;
                                2'd2: begin
                                    map_ctrl[7:0] <= rx_data;
                                    // only when the previous request has been answered.
                                    if (map_ctrl_req == ack_sync[1]) begin
                                        map_ctrl_req <= !map_ctrl_req;
                                    end
                                end
                                default: ;
                            endcase
                        end
                    end
                    st_data: begin
                        if (cmd == cmd_write) begin
                            second_byte <= !second_byte;
                            if (!second_byte) begin
                                if (low_first) begin
                                    ram_data[7:0] <= rx_data;
                                end else begin
                                    ram_data[15:8] <= rx_data;
                                end
                            end else begin
                                if (low_first) begin
                                    ram_data[15:8] <= rx_data;
                                end else begin
                                    ram_data[7:0] <= rx_data;
                                end
                                ram_req <= 1'b1;
                                if (first_write) begin
                                    first_write <= 1'b0;
                                end else begin
                                    ram_address <= ram_address + 1'b1;
                                end
                            end
                        end
                    end
                    default: state <= st_cmd;
                endcase
            end
        end
    end

    // at most one byte every two cycles.
    a_ready_single: assert property (
        @(posedge clk) disable iff (reset)
        rx_ready |=> !rx_ready
    );

    // writes only leave while streaming and never into a busy memory.
    a_req_when_idle: assert property (
        @(posedge clk) disable iff (reset)
        ram_req |-> !ram_busy && (state == st_data)
    );

endmodule

`default_nettype wire

//--- logic/loader_pkg.sv
`default_nettype none

package loader_pkg;

    // host command codes.
    localparam logic [7:0] cmd_write = 8'd1;
    localparam logic [7:0] cmd_launch = 8'd2;

    // word address and word width of the backing memory.
    localparam int ram_addr_width = 22;
    localparam int ram_data_width = 16;

    // control word handed to the accelerator.
    localparam int map_ctrl_width = 24;

    // frame decoder states.
    typedef enum logic [1:0] {
        st_cmd,
        st_addr,
        st_data
    } decode_state_t;

endpackage

`default_nettype wire

//--- logic/map_ctrl_receiver.sv
`timescale 1ns/1ps
`default_nettype none

module map_ctrl_receiver (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic [loader_pkg::map_ctrl_width-1:0] map_ctrl,
    input  logic                                  map_ctrl_req,
    output logic                                  map_ctrl_ack,
    output logic                                  launch,
    output logic [loader_pkg::map_ctrl_width-1:0] launch_map
);

    logic [1:0] req_sync;
    logic       req_change;

    // ack doubles as the last request level seen.
    assign req_change = (req_sync[1] != map_ctrl_ack);

    always_ff @(posedge clk) begin
        if (reset) begin
            req_sync     <= 2'b00;
            map_ctrl_ack <= 1'b0;
            launch       <= 1'b0;
        end else begin
            req_sync <= {req_sync[0], map_ctrl_req};
            launch   <= req_change;
            if (req_change) begin
                map_ctrl_ack <= req_sync[1];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req_change) begin
            launch_map <= map_ctrl;
        end
    end

    // sender must hold the control word across the capture.
    a_map_stable: assert property (
        @(posedge clk) disable iff (reset)
        req_change |-> $stable(map_ctrl)
    );

endmodule

`default_nettype wire

//--- logic/qspi_byte_rx.sv
`timescale 1ns/1ps
`default_nettype none

module qspi_byte_rx (
    input  logic       clk,
    input  logic       reset,
    input  logic       qspi_sck,
    input  logic       qspi_cs_n,
    input  logic [3:0] qspi_io,
    output logic [7:0] rx_data,
    output logic       rx_valid,
    output logic       rx_closed,
    output logic       overflow,
    input  logic       rx_ready
);

    logic [1:0] sck_sync;
    logic [1:0] cs_n_sync;
    logic [3:0] io_meta;
    logic [3:0] io_sync;
    logic       sck_prev;
    logic       sck_rise;
    logic       nibble_phase;
    logic [3:0] high_nibble;
    logic       transfer;

    // pin synchronizers, two stages each.
    always_ff @(posedge clk) begin
        if (reset) begin
            sck_sync  <= 2'b00;
            cs_n_sync <= 2'b11;
            sck_prev  <= 1'b0;
        end else begin
            sck_sync  <= {sck_sync[0], qspi_sck};
            cs_n_sync <= {cs_n_sync[0], qspi_cs_n};
            sck_prev  <= sck_sync[1];
        end
    end

    always_ff @(posedge clk) begin
        io_meta <= qspi_io;
        io_sync <= io_meta;
    end

    assign sck_rise  = sck_sync[1] && !sck_prev;
    assign rx_closed = cs_n_sync[1];
    assign transfer  = rx_valid && rx_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            rx_valid     <= 1'b0;
            overflow     <= 1'b0;
            nibble_phase <= 1'b0;
        end else begin
            if (transfer) begin
                rx_valid <= 1'b0;
            end

            if (cs_n_sync[1]) begin
                // idle link, restart on the high nibble.
                nibble_phase <= 1'b0;
            end else if (sck_rise) begin
                nibble_phase <= !nibble_phase;
                if (!nibble_phase) begin
                    high_nibble <= io_sync;
                end else if (rx_valid && !transfer) begin
                    // holding buffer still full, the new byte is lost.
                    overflow <= 1'b1;
                end else begin
                    rx_data  <= {high_nibble, io_sync};
                    rx_valid <= 1'b1;
                end
            end
        end
    end

    // an offered byte is held unchanged until the decoder takes it.
    a_hold_until_taken: assert property (
        @(posedge clk) disable iff (reset)
        rx_valid && !rx_ready |=> rx_valid && $stable(rx_data)
    );

endmodule

`default_nettype wire

//--- logic/qspi_loader.sv
`timescale 1ns/1ps
`default_nettype none

module qspi_loader #(
    parameter int ram_index_bits = 10,
    parameter int busy_cycles = 3
) (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  qspi_sck,
    input  logic                                  qspi_cs_n,
    input  logic [3:0]                            qspi_io,
    input  logic                                  rd_en,
    input  logic [loader_pkg::ram_addr_width-1:0] rd_address,
    output logic [loader_pkg::ram_data_width-1:0] rd_data,
    output logic                                  launch,
    output logic [loader_pkg::map_ctrl_width-1:0] launch_map,
    output logic                                  overflow
);

    import loader_pkg::*;

    logic [7:0]                rx_data;
    logic                      rx_valid;
    logic                      rx_ready;
    logic                      rx_closed;
    logic [ram_addr_width-1:0] ram_address;
    logic [ram_data_width-1:0] ram_data;
    logic                      ram_req;
    logic                      ram_busy;
    logic [map_ctrl_width-1:0] map_ctrl;
    logic                      map_ctrl_req;
    logic                      map_ctrl_ack;

    qspi_byte_rx u_qspi_byte_rx (
        .clk       (clk),
        .reset     (reset),
        .qspi_sck  (qspi_sck),
        .qspi_cs_n (qspi_cs_n),
        .qspi_io   (qspi_io),
        .rx_data   (rx_data),
        .rx_valid  (rx_valid),
        .rx_closed (rx_closed),
        .overflow  (overflow),
        .rx_ready  (rx_ready)
    );

    host_cmd_decoder u_host_cmd_decoder (
        .clk          (clk),
        .reset        (reset),
        .rx_data      (rx_data),
        .rx_valid     (rx_valid),
        .rx_closed    (rx_closed),
        .rx_ready     (rx_ready),
        .ram_address  (ram_address),
        .ram_data     (ram_data),
        .ram_req      (ram_req),
        .ram_busy     (ram_busy),
        .map_ctrl     (map_ctrl),
        .map_ctrl_req (map_ctrl_req),
        .map_ctrl_ack (map_ctrl_ack)
    );

    word_ram #(
        .ram_index_bits (ram_index_bits),
        .busy_cycles    (busy_cycles)
    ) u_word_ram (
        .clk         (clk),
        .reset       (reset),
        .ram_req     (ram_req),
        .ram_address (ram_address),
        .ram_data    (ram_data),
        .ram_busy    (ram_busy),
        .rd_en       (rd_en),
        .rd_address  (rd_address),
        .rd_data     (rd_data)
    );

    // accelerator side, same clock here.
    map_ctrl_receiver u_map_ctrl_receiver (
        .clk          (clk),
        .reset        (reset),
        .map_ctrl     (map_ctrl),
        .map_ctrl_req (map_ctrl_req),
        .map_ctrl_ack (map_ctrl_ack),
        .launch       (launch),
        .launch_map   (launch_map)
    );

endmodule

`default_nettype wire

//--- logic/word_ram.sv
`timescale 1ns/1ps
`default_nettype none

module word_ram #(
    parameter int ram_index_bits = 10,
    parameter int busy_cycles = 3
) (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  ram_req,
    input  logic [loader_pkg::ram_addr_width-1:0] ram_address,
    input  logic [loader_pkg::ram_data_width-1:0] ram_data,
    output logic                                  ram_busy,
    input  logic                                  rd_en,
    input  logic [loader_pkg::ram_addr_width-1:0] rd_address,
    output logic [loader_pkg::ram_data_width-1:0] rd_data
);

    import loader_pkg::*;

    localparam int depth = 2 ** ram_index_bits;
    localparam int count_bits = $clog2(busy_cycles + 1);

    logic [ram_data_width-1:0] mem [depth];
    logic [count_bits-1:0]     busy_count;

    // only the low address bits are backed by storage.
    always_ff @(posedge clk) begin
        if (ram_req) begin
            mem[ram_address[ram_index_bits-1:0]] <= ram_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_address[ram_index_bits-1:0]];
        end
    end

    // busy interval, as the SDRAM controller would show it.
    always_ff @(posedge clk) begin
        if (reset) begin
            busy_count <= '0;
        end else if (ram_req) begin
            busy_count <= count_bits'(busy_cycles);
        end else if (busy_count != '0) begin
            busy_count <= busy_count - 1'b1;
        end
    end

    assign ram_busy = (busy_count != '0);

endmodule

`default_nettype wire

//--- testbench/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter real period = 8.0
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    // free running, 50 percent duty.
    always #(period / 2.0) clk = ~clk;

endmodule

`default_nettype wire

//--- testbench/tb_qspi_loader.sv
`timescale 1ns/1ps
`default_nettype none

module tb_qspi_loader;

    import loader_pkg::*;

    localparam int index_bits = 10;
    localparam int launch_timeout = 200;

    typedef logic [7:0] byte_list_t [$];

    logic                      clk;
    logic                      reset;
    logic                      qspi_sck;
    logic                      qspi_cs_n;
    logic [3:0]                qspi_io;
    logic                      rd_en;
    logic [ram_addr_width-1:0] rd_address;
    logic [ram_data_width-1:0] rd_data;
    logic                      launch;
    logic [map_ctrl_width-1:0] launch_map;
    logic                      overflow;
    int                        launch_count;

    // expected memory contents, keyed by stored index.
    logic [ram_data_width-1:0] model_mem [int];

    tb_clock #(.period(8.0)) u_tb_clock (.clk(clk));

    qspi_loader #(
        .ram_index_bits (index_bits),
        .busy_cycles    (3)
    ) u_qspi_loader (
        .clk        (clk),
        .reset      (reset),
        .qspi_sck   (qspi_sck),
        .qspi_cs_n  (qspi_cs_n),
        .qspi_io    (qspi_io),
        .rd_en      (rd_en),
        .rd_address (rd_address),
        .rd_data    (rd_data),
        .launch     (launch),
        .launch_map (launch_map),
        .overflow   (overflow)
    );

    always @(posedge clk) begin
        if (reset) begin
            launch_count <= 0;
        end else if (launch) begin
            launch_count <= launch_count + 1;
        end
    end

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        assert (got === expected) else begin
            $display("FAIL time=%0t %s got=%0h expected=%0h", $time, name, got, expected);
            $display("Result: FAILED");
            $fatal(1);
        end
    endtask

    // two nibbles, high first, sampled on the rising sck.
    task automatic send_byte(input logic [7:0] value);
        qspi_sck = 1'b0;
        qspi_io  = value[7:4];
        repeat (4) next_cycle();
        qspi_sck = 1'b1;
        repeat (4) next_cycle();
        qspi_sck = 1'b0;
        qspi_io  = value[3:0];
        repeat (4) next_cycle();
        qspi_sck = 1'b1;
        repeat (4) next_cycle();
    endtask

    task automatic send_frame(input byte_list_t bytes);
        qspi_cs_n = 1'b0;
        repeat (2) next_cycle();
        foreach (bytes[i]) begin
            send_byte(bytes[i]);
        end
        qspi_sck  = 1'b0;
        qspi_io   = 4'h0;
        qspi_cs_n = 1'b1;
        repeat (6) next_cycle();
    endtask

    task automatic read_word(input int index, input logic [ram_data_width-1:0] expected);
        rd_en      = 1'b1;
        rd_address = ram_addr_width'(index);
        next_cycle();
        rd_en = 1'b0;
        check_value($sformatf("rd_data[%0h]", index), 32'(rd_data), 32'(expected));
    endtask

    function automatic byte_list_t random_bytes(input int count);
        byte_list_t list;
        for (int i = 0; i < count; i++) begin
            list.push_back(8'($urandom()));
        end
        return list;
    endfunction

    // address splits 7, 8, 7 bits, lane flag in the last bit.
    function automatic byte_list_t frame_header(input logic [7:0] cmd,
                                                input logic [ram_addr_width-1:0] addr,
                                                input logic lane);
        byte_list_t frame;
        frame.push_back(cmd);
        frame.push_back({1'b0, addr[21:15]});
        frame.push_back(addr[14:7]);
        frame.push_back({addr[6:0], lane});
        return frame;
    endfunction

    task automatic check_memory();
        foreach (model_mem[idx]) begin
            read_word(idx, model_mem[idx]);
        end
    endtask

    task automatic write_words(input logic [ram_addr_width-1:0] addr, input logic lane,
                               input byte_list_t data);
        byte_list_t frame;
        int         index;
        frame = frame_header(cmd_write, addr, lane);
        foreach (data[i]) begin
            frame.push_back(data[i]);
        end
        send_frame(frame);
        for (int w = 0; w < data.size() / 2; w++) begin
            index = int'((addr + w) & ((1 << index_bits) - 1));
            if (lane) begin
                model_mem[index] = {data[2 * w + 1], data[2 * w]};
            end else begin
                model_mem[index] = {data[2 * w], data[2 * w + 1]};
            end
        end
    endtask

    task automatic wait_launch(input int target);
        int cycles;
        cycles = 0;
        while (launch_count < target) begin
            if (cycles >= launch_timeout) begin
                $display("launch pulse did not arrive within %0d cycles", launch_timeout);
                $display("Result: FAILED");
                $fatal(1);
            end
            next_cycle();
            cycles++;
        end
    endtask

    task automatic expect_quiet(input int cycles, input int count);
        for (int i = 0; i < cycles; i++) begin
            next_cycle();
            check_value("launch_count", launch_count, count);
        end
    endtask

    task automatic test_write_even();
        write_words(22'h2a_5140, 1'b0, random_bytes(8));
        check_memory();
    endtask

    task automatic test_write_low_first();
        write_words(22'h01_0200, 1'b1, random_bytes(8));
        check_memory();
    endtask

    task automatic launch_and_check(input int target);
        byte_list_t map;
        byte_list_t frame;
        map   = random_bytes(3);
        frame = map;
        frame.push_front(cmd_launch);
        send_frame(frame);
        wait_launch(target);
        expect_quiet(20, target);
        check_value("launch_map", 32'(launch_map), {8'h00, map[0], map[1], map[2]});
    endtask

    task automatic test_launch_once();
        launch_and_check(launch_count + 1);
    endtask

    task automatic test_aborted_frame();
        byte_list_t frame;
        frame.push_back(cmd_write);
        frame.push_back(8'h00);
        frame.push_back(8'h03);
        send_frame(frame);
        write_words(22'h00_0380, 1'b0, random_bytes(2));
        check_memory();
    endtask

    task automatic test_unknown_command();
        byte_list_t frame;
        byte_list_t data;
        int         count;
        count = launch_count;
        // header of an earlier write, so a stray store lands on checked words.
        frame = frame_header(8'h07, 22'h2a_5140, 1'b0);
        data  = random_bytes(4);
        foreach (data[i]) begin
            frame.push_back(data[i]);
        end
        send_frame(frame);
        expect_quiet(30, count);
        check_memory();
    endtask

    task automatic test_two_launches();
        launch_and_check(launch_count + 1);
        launch_and_check(launch_count + 1);
    endtask

    initial begin
        void'($urandom(76));
        reset      = 1'b1;
        qspi_sck   = 1'b0;
        qspi_cs_n  = 1'b1;
        qspi_io    = 4'h0;
        rd_en      = 1'b0;
        rd_address = '0;
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;
        next_cycle();

        test_write_even();
        test_write_low_first();
        test_launch_once();
        test_aborted_frame();
        test_unknown_command();
        test_two_launches();
        check_value("overflow", 32'(overflow), 32'd0);

        $display("Result: PASSED");
        $finish;
    end

endmodule

`default_nettype wire
